//--- wakeupPipe_defs.svh
// --------------------
// Sizes of the wakeup pipeline register
// Entry counts must be powers of two
// Memory latency must be at least 1
// --------------------

`ifndef WAKEUP_PIPE_DEFS_SVH
`define WAKEUP_PIPE_DEFS_SVH

// Issue queue entries
`define WP_IQ_ENTRIES 16

// Active list entries
`define WP_AL_ENTRIES 32

// Issue widths per pipe
`define WP_INT_WIDTH 2
`define WP_MEM_WIDTH 1

// Cycles from select to wakeup on the memory pipe
`define WP_MEM_LATENCY 3

// Selection, wakeup and release slots
`define WP_ISSUE_WIDTH (`WP_INT_WIDTH + `WP_MEM_WIDTH)

`endif

//--- recoveryPkg.sv
// --------------------
// Active list types and flush range test
// A range [head, tail) may wrap around
// --------------------

`default_nettype none

`include "wakeupPipe_defs.svh"

package recoveryPkg;

    // Active list index
    typedef logic [$clog2(`WP_AL_ENTRIES)-1:0] alIndexT;

    // Where the recovery was started from
    typedef enum logic {
        recoverFull   = 1'b0,
        recoverFromRw = 1'b1
    } recoveryKindT;

    // True when ptr lies in the flushed part of the active list
    function automatic logic inFlushRange(
        input alIndexT head,
        input alIndexT tail,
        input logic    flushAll,
        input alIndexT ptr
    );
        logic hit;
        if (flushAll) begin
            hit = 1'b1;
        end else if (head <= tail) begin
            hit = (ptr >= head) && (ptr < tail);
        end else begin
            // Wrapped range
            hit = (ptr >= head) || (ptr < tail);
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

//--- schedulerPkg.sv
// --------------------
// Issue queue types
// Needs recoveryPkg compiled first
// --------------------

`default_nettype none

`include "wakeupPipe_defs.svh"

package schedulerPkg;

    // Issue queue entry index
    typedef logic [$clog2(`WP_IQ_ENTRIES)-1:0] iqIndexT;

    // One bit per issue queue entry
    typedef logic [`WP_IQ_ENTRIES-1:0] iqOneHotT;

    // An issued op while it waits for its unit latency
    typedef struct packed {
        logic                 valid;
        iqIndexT              ptr;
        // Consumers woken when the op leaves
        iqOneHotT             depVector;
        // Used to match a selective flush range
        recoveryPkg::alIndexT alPtr;
    } trackedOpT;

endpackage

`default_nettype wire

//--- flushRangeTracker.sv
// --------------------
// Recovery capture and flush windows
// toRecovery is expected as a one cycle pulse
// The range outputs are meaningful only inside a window
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "wakeupPipe_defs.svh"

module flushRangeTracker (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      stall,
    input  logic                      toRecovery,
    input  recoveryPkg::recoveryKindT recoveryKind,
    input  recoveryPkg::alIndexT      flushHeadPtr,
    input  recoveryPkg::alIndexT      flushTailPtr,
    input  logic                      flushAll,
    output logic                      fullFlush,
    output logic                      intWindow,
    output logic                      memWindow,
    output logic                      flushedOpExist,
    output recoveryPkg::alIndexT      rangeHead,
    output recoveryPkg::alIndexT      rangeTail,
    output logic                      rangeAll
);

    localparam int NumPipes = 2;
    localparam int CountW   = $clog2(`WP_MEM_LATENCY + 1);

    // Index 0 is the integer pipe, index 1 the memory pipe
    localparam logic [CountW-1:0] PipeLatency [NumPipes] = '{
        CountW'(1),
        CountW'(`WP_MEM_LATENCY)
    };

    logic              selectiveFlush;
    logic [CountW-1:0] flushCount [NumPipes];

    assign fullFlush      = toRecovery && (recoveryKind == recoveryPkg::recoverFull);
    assign selectiveFlush = toRecovery && (recoveryKind == recoveryPkg::recoverFromRw);

    // Stages that may still hold a flushed op
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int p = 0; p < NumPipes; p++) begin
                flushCount[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NumPipes; p++) begin
                if (selectiveFlush) begin
                    flushCount[p] <= PipeLatency[p];
                end else if (flushCount[p] == PipeLatency[p]) begin
                    // Entry stage does not move under stall
                    if (!stall) begin
                        flushCount[p] <= flushCount[p] - 1'b1;
                    end
                end else if (flushCount[p] != '0) begin
                    flushCount[p] <= flushCount[p] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (selectiveFlush) begin
            rangeHead <= flushHeadPtr;
            rangeTail <= flushTailPtr;
            rangeAll  <= flushAll;
        end
    end

    assign intWindow      = (flushCount[0] != '0);
    assign memWindow      = (flushCount[1] != '0);
    assign flushedOpExist = intWindow || memWindow;

endmodule

`default_nettype wire

//--- wakeupDelayLine.sv
// --------------------
// Shift line of tracked ops, one op per lane and stage
// Stall holds only the entry stage
// Later stages keep draining behind a bubble
// --------------------

`timescale 1ns/1ps
`default_nettype none

module wakeupDelayLine #(
    parameter int Lanes   = 1,
    parameter int Latency = 1
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    fullFlush,
    input  schedulerPkg::trackedOpT enterOp [Lanes],
    output schedulerPkg::trackedOpT headOp  [Lanes]
);

    // Stage 0 is the head and stage Latency-1 takes new selections
    logic                    validQ [Lanes][Latency];
    schedulerPkg::trackedOpT opQ    [Lanes][Latency];
    schedulerPkg::trackedOpT stage  [Lanes][Latency];
    schedulerPkg::trackedOpT nextOp [Lanes][Latency];

    for (genvar l = 0; l < Lanes; l++) begin : gLane
        for (genvar s = 0; s < Latency; s++) begin : gStage

            // Valid lives in its own reset flop
            always_comb begin
                stage[l][s]       = opQ[l][s];
                stage[l][s].valid = validQ[l][s];
            end

            if (s == Latency - 1) begin : gEntry
                // Selections made during stall are dropped
                assign nextOp[l][s] = stall ? stage[l][s] : enterOp[l];
            end else begin : gShift
                always_comb begin
                    nextOp[l][s] = stage[l][s + 1];
                    // Bubble behind the held entry stage
                    if (stall && (s == Latency - 2)) begin
                        nextOp[l][s].valid     = 1'b0;
                        nextOp[l][s].depVector = '0;
                    end
                end
            end

            always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                    validQ[l][s] <= 1'b0;
                end else if (fullFlush) begin
                    validQ[l][s] <= 1'b0;
                end else begin
                    validQ[l][s] <= nextOp[l][s].valid;
                end
            end

            always_ff @(posedge clk) begin
                opQ[l][s] <= nextOp[l][s];
            end

        end

        assign headOp[l] = stage[l][0];
    end

endmodule

`default_nettype wire

//--- wakeupDrive.sv
// --------------------
// Wakeup and release from the pipe heads
// Integer outputs are zero under stall
// Memory outputs ignore stall
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "wakeupPipe_defs.svh"

module wakeupDrive (
    input  logic                    stall,
    input  logic                    intWindow,
    input  logic                    memWindow,
    input  logic                    rangeAll,
    input  recoveryPkg::alIndexT    rangeHead,
    input  recoveryPkg::alIndexT    rangeTail,
    input  schedulerPkg::trackedOpT intHead      [`WP_INT_WIDTH],
    input  schedulerPkg::trackedOpT memHead      [`WP_MEM_WIDTH],
    output logic                    wakeup       [`WP_ISSUE_WIDTH],
    output logic                    releaseEntry [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqIndexT   wakeupPtr    [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqIndexT   releasePtr   [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqOneHotT  wakeupVector [`WP_ISSUE_WIDTH]
);

    logic intFlushed [`WP_INT_WIDTH];
    logic memFlushed [`WP_MEM_WIDTH];

    // Integer lanes take the low slots
    always_comb begin
        for (int i = 0; i < `WP_INT_WIDTH; i++) begin
            intFlushed[i] = intWindow && recoveryPkg::inFlushRange(
                rangeHead, rangeTail, rangeAll, intHead[i].alPtr);

            wakeup[i]       = intHead[i].valid && !intFlushed[i] && !stall;
            wakeupPtr[i]    = intHead[i].ptr;
            wakeupVector[i] = stall ? '0 : intHead[i].depVector;

            // A flushed op still gives its entry back
            releaseEntry[i] = intHead[i].valid && !stall;
            releasePtr[i]   = intHead[i].ptr;
        end
    end

    // Memory lanes follow the integer slots
    always_comb begin
        for (int j = 0; j < `WP_MEM_WIDTH; j++) begin
            memFlushed[j] = memWindow && recoveryPkg::inFlushRange(
                rangeHead, rangeTail, rangeAll, memHead[j].alPtr);

            wakeup[`WP_INT_WIDTH + j]       = memHead[j].valid && !memFlushed[j];
            wakeupPtr[`WP_INT_WIDTH + j]    = memHead[j].ptr;
            wakeupVector[`WP_INT_WIDTH + j] = memHead[j].depVector;

            releaseEntry[`WP_INT_WIDTH + j] = memHead[j].valid;
            releasePtr[`WP_INT_WIDTH + j]   = memHead[j].ptr;
        end
    end

endmodule

`default_nettype wire

//--- wakeupPipelineRegister.sv
// --------------------
// Wakeup pipeline register of the issue queue
// Integer latency is fixed at 1
// Memory lanes take the slots after the integer lanes
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "wakeupPipe_defs.svh"

module wakeupPipelineRegister (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      stall,
    input  logic                      selected       [`WP_ISSUE_WIDTH],
    input  schedulerPkg::iqIndexT     selectedPtr    [`WP_ISSUE_WIDTH],
    input  schedulerPkg::iqOneHotT    selectedVector [`WP_ISSUE_WIDTH],
    input  recoveryPkg::alIndexT      selectedAlPtr  [`WP_ISSUE_WIDTH],
    input  schedulerPkg::iqOneHotT    flushIqEntry,
    input  logic                      toRecovery,
    input  recoveryPkg::recoveryKindT recoveryKind,
    input  recoveryPkg::alIndexT      flushHeadPtr,
    input  recoveryPkg::alIndexT      flushTailPtr,
    input  logic                      flushAll,
    output logic                      wakeup         [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqIndexT     wakeupPtr      [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqOneHotT    wakeupVector   [`WP_ISSUE_WIDTH],
    output logic                      releaseEntry   [`WP_ISSUE_WIDTH],
    output schedulerPkg::iqIndexT     releasePtr     [`WP_ISSUE_WIDTH],
    output logic                      flushedOpExist
);

    logic                    fullFlush;
    logic                    intWindow;
    logic                    memWindow;
    logic                    rangeAll;
    recoveryPkg::alIndexT    rangeHead;
    recoveryPkg::alIndexT    rangeTail;
    schedulerPkg::trackedOpT intEnter [`WP_INT_WIDTH];
    schedulerPkg::trackedOpT memEnter [`WP_MEM_WIDTH];
    schedulerPkg::trackedOpT intHead  [`WP_INT_WIDTH];
    schedulerPkg::trackedOpT memHead  [`WP_MEM_WIDTH];

    // Drop a selection whose entry is flushed in the same cycle
    function automatic schedulerPkg::trackedOpT captureOp(
        input logic                   sel,
        input schedulerPkg::iqIndexT  ptr,
        input schedulerPkg::iqOneHotT vector,
        input recoveryPkg::alIndexT   alPtr,
        input schedulerPkg::iqOneHotT flushMask
    );
        schedulerPkg::trackedOpT op;
        op.valid     = sel && !flushMask[ptr];
        op.ptr       = ptr;
        op.depVector = vector;
        op.alPtr     = alPtr;
        return op;
    endfunction

    always_comb begin
        for (int i = 0; i < `WP_INT_WIDTH; i++) begin
            intEnter[i] = captureOp(selected[i], selectedPtr[i], selectedVector[i],
                                    selectedAlPtr[i], flushIqEntry);
        end
        for (int j = 0; j < `WP_MEM_WIDTH; j++) begin
            memEnter[j] = captureOp(selected[`WP_INT_WIDTH + j],
                                    selectedPtr[`WP_INT_WIDTH + j],
                                    selectedVector[`WP_INT_WIDTH + j],
                                    selectedAlPtr[`WP_INT_WIDTH + j],
                                    flushIqEntry);
        end
    end

    flushRangeTracker u_tracker (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .toRecovery     (toRecovery),
        .recoveryKind   (recoveryKind),
        .flushHeadPtr   (flushHeadPtr),
        .flushTailPtr   (flushTailPtr),
        .flushAll       (flushAll),
        .fullFlush      (fullFlush),
        .intWindow      (intWindow),
        .memWindow      (memWindow),
        .flushedOpExist (flushedOpExist),
        .rangeHead      (rangeHead),
        .rangeTail      (rangeTail),
        .rangeAll       (rangeAll)
    );

    wakeupDelayLine #(
        .Lanes   (`WP_INT_WIDTH),
        .Latency (1)
    ) u_intLine (
        .clk       (clk),
        .arstN     (arstN),
        .stall     (stall),
        .fullFlush (fullFlush),
        .enterOp   (intEnter),
        .headOp    (intHead)
    );

    wakeupDelayLine #(
        .Lanes   (`WP_MEM_WIDTH),
        .Latency (`WP_MEM_LATENCY)
    ) u_memLine (
        .clk       (clk),
        .arstN     (arstN),
        .stall     (stall),
        .fullFlush (fullFlush),
        .enterOp   (memEnter),
        .headOp    (memHead)
    );

    wakeupDrive u_drive (
        .stall        (stall),
        .intWindow    (intWindow),
        .memWindow    (memWindow),
        .rangeAll     (rangeAll),
        .rangeHead    (rangeHead),
        .rangeTail    (rangeTail),
        .intHead      (intHead),
        .memHead      (memHead),
        .wakeup       (wakeup),
        .releaseEntry (releaseEntry),
        .wakeupPtr    (wakeupPtr),
        .releasePtr   (releasePtr),
        .wakeupVector (wakeupVector)
    );

endmodule

`default_nettype wire

//--- tbClockGen.sv
// --------------------
// Clock and reset for the testbench
// Reset is released on the rising edge after ResetCycles edges
// --------------------

`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter real HalfPeriod  = 2.0,
    parameter int  ResetCycles = 8
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HalfPeriod) clk = ~clk;
        end
    end

    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- wakeupPipelineTb.sv
// --------------------
// Testbench of the wakeup pipeline register
// A reference model steps on the falling edge and assertions compare it
// Slot numbers assume two integer lanes and one memory lane
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "wakeupPipe_defs.svh"

module wakeupPipelineTb;

    localparam int          IntW       = `WP_INT_WIDTH;
    localparam int          Slots      = `WP_ISSUE_WIDTH;
    localparam int          MemLat     = `WP_MEM_LATENCY;
    localparam logic [15:0] RandomSeed = 16'd52;
    // Reset, integer, memory, stall, mask, selective and full flush phases
    localparam int PhaseCycles   = 8 + 11 + 11 + 9 + 11 + 35 + 10;
    localparam int TimeoutCycles = 2 * PhaseCycles;

    logic                      clk;
    logic                      arstN;
    logic                      stall;
    logic                      selected       [Slots];
    schedulerPkg::iqIndexT     selectedPtr    [Slots];
    schedulerPkg::iqOneHotT    selectedVector [Slots];
    recoveryPkg::alIndexT      selectedAlPtr  [Slots];
    schedulerPkg::iqOneHotT    flushIqEntry;
    logic                      toRecovery;
    recoveryPkg::recoveryKindT recoveryKind;
    recoveryPkg::alIndexT      flushHeadPtr;
    recoveryPkg::alIndexT      flushTailPtr;
    logic                      flushAll;
    logic                      wakeup         [Slots];
    schedulerPkg::iqIndexT     wakeupPtr      [Slots];
    schedulerPkg::iqOneHotT    wakeupVector   [Slots];
    logic                      releaseEntry   [Slots];
    schedulerPkg::iqIndexT     releasePtr     [Slots];
    logic                      flushedOpExist;

    // Reference model with the memory pipe head at stage 0
    schedulerPkg::trackedOpT modelInt [IntW];
    schedulerPkg::trackedOpT modelMem [MemLat];
    int                      modelIntCount;
    int                      modelMemCount;
    recoveryPkg::alIndexT    modelHead;
    recoveryPkg::alIndexT    modelTail;
    logic                    modelAll;

    logic [15:0]           lfsrState;
    schedulerPkg::iqIndexT lastPtr;
    int                    errorCount;
    int                    checkCount;
    int                    cycleCount;

    tbClockGen #(.HalfPeriod(2.0), .ResetCycles(8)) u_clockGen (.clk(clk), .arstN(arstN));

    wakeupPipelineRegister u_dut (
        .clk            (clk),
        .arstN          (arstN),
        .stall          (stall),
        .selected       (selected),
        .selectedPtr    (selectedPtr),
        .selectedVector (selectedVector),
        .selectedAlPtr  (selectedAlPtr),
        .flushIqEntry   (flushIqEntry),
        .toRecovery     (toRecovery),
        .recoveryKind   (recoveryKind),
        .flushHeadPtr   (flushHeadPtr),
        .flushTailPtr   (flushTailPtr),
        .flushAll       (flushAll),
        .wakeup         (wakeup),
        .wakeupPtr      (wakeupPtr),
        .wakeupVector   (wakeupVector),
        .releaseEntry   (releaseEntry),
        .releasePtr     (releasePtr),
        .flushedOpExist (flushedOpExist)
    );

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic takeRandom(input int nBits, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < nBits; b++) begin
            value[b] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Offset from head below the span means inside, wrapped or not
    function automatic logic ptrInRange(
        input recoveryPkg::alIndexT head,
        input recoveryPkg::alIndexT tail,
        input recoveryPkg::alIndexT ptr,
        input logic                 all
    );
        recoveryPkg::alIndexT span;
        recoveryPkg::alIndexT offset;
        span   = tail - head;
        offset = ptr - head;
        return all || (offset < span);
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        errorCount++;
        $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
    endtask

    task automatic checkSlot(input int slot, input schedulerPkg::trackedOpT op,
                             input logic window, input logic gated);
        logic expRel;
        logic expWake;
        expRel  = op.valid && !gated;
        expWake = expRel && !(window && ptrInRange(modelHead, modelTail, op.alPtr, modelAll));
        checkCount++;
        assert (wakeup[slot] === expWake)
            else reportValue($sformatf("wakeup[%0d]", slot), expWake, wakeup[slot]);
        assert (releaseEntry[slot] === expRel)
            else reportValue($sformatf("releaseEntry[%0d]", slot), expRel, releaseEntry[slot]);
        if (expRel) begin
            assert (releasePtr[slot] === op.ptr)
                else reportValue($sformatf("releasePtr[%0d]", slot), op.ptr, releasePtr[slot]);
        end
        if (expWake) begin
            assert (wakeupPtr[slot] === op.ptr)
                else reportValue($sformatf("wakeupPtr[%0d]", slot), op.ptr, wakeupPtr[slot]);
            assert (wakeupVector[slot] === op.depVector)
                else reportValue($sformatf("wakeupVector[%0d]", slot), op.depVector,
                                 wakeupVector[slot]);
        end
        if (gated) begin
            assert (wakeupVector[slot] === '0)
                else reportValue($sformatf("wakeupVector[%0d]", slot), 0, wakeupVector[slot]);
        end
    endtask

    task automatic checkOutputs();
        logic expExist;
        for (int i = 0; i < IntW; i++) begin
            checkSlot(i, modelInt[i], modelIntCount != 0, stall);
        end
        checkSlot(IntW, modelMem[0], modelMemCount != 0, 1'b0);
        expExist = (modelIntCount != 0) || (modelMemCount != 0);
        assert (flushedOpExist === expExist)
            else reportValue("flushedOpExist", expExist, flushedOpExist);
    endtask

    task automatic resetModel();
        for (int i = 0; i < IntW; i++) begin
            modelInt[i] = '0;
        end
        for (int s = 0; s < MemLat; s++) begin
            modelMem[s] = '0;
        end
        modelIntCount = 0;
        modelMemCount = 0;
    endtask

    // Next model state from the inputs the DUT takes at the coming edge
    task automatic advanceModel();
        schedulerPkg::trackedOpT entering [Slots];
        for (int i = 0; i < Slots; i++) begin
            entering[i].valid     = selected[i] && !flushIqEntry[selectedPtr[i]];
            entering[i].ptr       = selectedPtr[i];
            entering[i].depVector = selectedVector[i];
            entering[i].alPtr     = selectedAlPtr[i];
        end
        for (int s = 0; s < MemLat - 1; s++) begin
            modelMem[s] = modelMem[s + 1];
            if (stall && (s == MemLat - 2)) begin
                modelMem[s].valid = 1'b0;
            end
        end
        if (!stall) begin
            for (int i = 0; i < IntW; i++) begin
                modelInt[i] = entering[i];
            end
            modelMem[MemLat - 1] = entering[IntW];
        end
        if (toRecovery && (recoveryKind == recoveryPkg::recoverFull)) begin
            for (int i = 0; i < IntW; i++) begin
                modelInt[i].valid = 1'b0;
            end
            for (int s = 0; s < MemLat; s++) begin
                modelMem[s].valid = 1'b0;
            end
        end
        if (toRecovery && (recoveryKind == recoveryPkg::recoverFromRw)) begin
            modelIntCount = 1;
            modelMemCount = MemLat;
            modelHead     = flushHeadPtr;
            modelTail     = flushTailPtr;
            modelAll      = flushAll;
        end else begin
            // A full counter waits for a cycle without stall
            if ((modelIntCount > 0) && !((modelIntCount == 1) && stall)) begin
                modelIntCount--;
            end
            if ((modelMemCount > 0) && !((modelMemCount == MemLat) && stall)) begin
                modelMemCount--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            resetModel();
        end
        checkOutputs();
        if (arstN) begin
            advanceModel();
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("Finished with errors");
            $finish;
        end
    end

    // One-cycle inputs return to idle at every edge
    task automatic nextCycle();
        @(posedge clk);
        stall        <= 1'b0;
        toRecovery   <= 1'b0;
        flushIqEntry <= '0;
        for (int i = 0; i < Slots; i++) begin
            selected[i] <= 1'b0;
        end
    endtask

    task automatic driveOp(input int slot, input recoveryPkg::alIndexT al);
        logic [31:0] ptrBits;
        logic [31:0] vecBits;
        takeRandom($bits(schedulerPkg::iqIndexT), ptrBits);
        takeRandom($bits(schedulerPkg::iqOneHotT), vecBits);
        lastPtr = schedulerPkg::iqIndexT'(ptrBits);
        selected[slot]       <= 1'b1;
        selectedPtr[slot]    <= lastPtr;
        selectedVector[slot] <= schedulerPkg::iqOneHotT'(vecBits);
        selectedAlPtr[slot]  <= al;
    endtask

    task automatic driveRandomOp(input int slot);
        logic [31:0] alBits;
        takeRandom($bits(recoveryPkg::alIndexT), alBits);
        driveOp(slot, recoveryPkg::alIndexT'(alBits));
    endtask

    task automatic pulseRecovery(input recoveryPkg::recoveryKindT kind,
                                 input recoveryPkg::alIndexT head,
                                 input recoveryPkg::alIndexT tail, input logic all);
        toRecovery   <= 1'b1;
        recoveryKind <= kind;
        flushHeadPtr <= head;
        flushTailPtr <= tail;
        flushAll     <= all;
    endtask

    // Ops on both sides of the range in flight when the recovery arrives
    task automatic selectiveCase(input recoveryPkg::alIndexT head, input recoveryPkg::alIndexT tail,
                                 input logic all, input recoveryPkg::alIndexT inAl,
                                 input recoveryPkg::alIndexT outAl, input logic stallAfter);
        logic busy;
        for (int c = 0; c < 4; c++) begin
            nextCycle();
            driveOp(0, inAl);
            driveOp(1, outAl);
            driveOp(2, (c % 2 == 1) ? inAl : outAl);
        end
        nextCycle();
        driveOp(0, inAl);
        driveOp(1, outAl);
        driveOp(2, inAl);
        pulseRecovery(recoveryPkg::recoverFromRw, head, tail, all);
        if (stallAfter) begin
            for (int c = 0; c < 2; c++) begin
                nextCycle();
                stall <= 1'b1;
            end
        end
        busy = 1'b1;
        while (busy) begin
            nextCycle();
            @(negedge clk);
            busy = flushedOpExist;
        end
        repeat (2) nextCycle();
    endtask

    initial begin
        lfsrState  = RandomSeed;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        lastPtr    = '0;
        stall        <= 1'b0;
        flushIqEntry <= '0;
        toRecovery   <= 1'b0;
        recoveryKind <= recoveryPkg::recoverFull;
        flushHeadPtr <= '0;
        flushTailPtr <= '0;
        flushAll     <= 1'b0;
        for (int i = 0; i < Slots; i++) begin
            selected[i]       <= 1'b0;
            selectedPtr[i]    <= '0;
            selectedVector[i] <= '0;
            selectedAlPtr[i]  <= '0;
        end
        @(posedge arstN);

        // Integer pipe with both lanes
        for (int c = 0; c < 8; c++) begin
            nextCycle();
            driveRandomOp(0);
            if (c % 3 != 2) begin
                driveRandomOp(1);
            end
        end
        repeat (3) nextCycle();

        // Back-to-back memory ops
        for (int c = 0; c < 6; c++) begin
            nextCycle();
            driveRandomOp(2);
        end
        repeat (5) nextCycle();

        // Stall with one memory op in the entry stage and one further on
        nextCycle();
        driveRandomOp(2);
        driveRandomOp(0);
        nextCycle();
        driveRandomOp(2);
        driveRandomOp(1);
        for (int c = 0; c < 2; c++) begin
            nextCycle();
            stall <= 1'b1;
            for (int s = 0; s < Slots; s++) begin
                driveRandomOp(s);
            end
        end
        repeat (5) nextCycle();

        // Selections whose entry is flushed in the same cycle
        for (int c = 0; c < 6; c++) begin
            nextCycle();
            driveRandomOp(0);
            flushIqEntry[lastPtr] <= 1'b1;
            driveRandomOp(1);
            driveRandomOp(2);
            flushIqEntry[lastPtr] <= 1'b1;
        end
        repeat (5) nextCycle();

        // Selective flush with plain, wrapped and whole ranges
        selectiveCase(5'd4, 5'd12, 1'b0, 5'd7, 5'd12, 1'b1);
        selectiveCase(5'd28, 5'd6, 1'b0, 5'd30, 5'd15, 1'b0);
        selectiveCase(5'd10, 5'd10, 1'b1, 5'd3, 5'd20, 1'b0);

        // Full flush drops everything in flight, even ops selected with it
        for (int c = 0; c < 3; c++) begin
            nextCycle();
            for (int s = 0; s < Slots; s++) begin
                driveRandomOp(s);
            end
        end
        nextCycle();
        for (int s = 0; s < Slots; s++) begin
            driveRandomOp(s);
        end
        pulseRecovery(recoveryPkg::recoverFull, '0, '0, 1'b0);
        repeat (5) nextCycle();

        // Let the last model check run before the summary
        @(negedge clk);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
recoveryPkg.sv
schedulerPkg.sv
flushRangeTracker.sv
wakeupDelayLine.sv
wakeupDrive.sv
wakeupPipelineRegister.sv
tbClockGen.sv
wakeupPipelineTb.sv

//--- Bender.yml
package:
  name: wakeup_pipeline_register

sources:
  - include_dirs:
      - .
    files:
      - recoveryPkg.sv
      - schedulerPkg.sv
      - flushRangeTracker.sv
      - wakeupDelayLine.sv
      - wakeupDrive.sv
      - wakeupPipelineRegister.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClockGen.sv
      - wakeupPipelineTb.sv
